/* hw/axi_mux_pkg.sv */
// --------------------
// Widths and vector types shared by the AXI4 multiplexer
// Manager-side IDs are SlvIdWidth bits wide
// The subordinate side adds clog2(NumPorts) bits above them
// Only id, addr, len, data, strb, last and resp are carried
// --------------------
package axi_mux_pkg;

  // Field widths
  parameter int unsigned SlvIdWidth = 4;
  parameter int unsigned AddrWidth  = 32;
  parameter int unsigned DataWidth  = 32;
  parameter int unsigned StrbWidth  = DataWidth / 8;
  parameter int unsigned LenWidth   = 8;
  parameter int unsigned RespWidth  = 2;

  // --------------------
  // Channel field types
  // --------------------

  // ID as seen at a manager port
  typedef logic [SlvIdWidth-1:0] slv_id_t;

  typedef logic [AddrWidth-1:0] addr_t;

  // One data beat and its byte strobes
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // Number of beats minus one
  typedef logic [LenWidth-1:0] len_t;

  typedef logic [RespWidth-1:0] resp_t;

endpackage

/* hw/rr_arbiter.sv */
// --------------------
// Round-robin arbiter for AW or AR requests
// A grant that is valid but not accepted stays locked
// Requesters must hold valid and payload until accepted
// --------------------
module rr_arbiter import axi_mux_pkg::*; #(
  parameter int unsigned  NumPorts   = 4,
  localparam int unsigned IdxWidth   = $clog2(NumPorts),
  localparam int unsigned MstIdWidth = SlvIdWidth + IdxWidth
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [NumPorts-1:0]     req_valid_i,
  input  slv_id_t [NumPorts-1:0]  req_id_i,
  input  addr_t [NumPorts-1:0]    req_addr_i,
  input  len_t [NumPorts-1:0]     req_len_i,
  input  logic                    gnt_ready_i,
  output logic [NumPorts-1:0]     req_ready_o,
  output logic                    gnt_valid_o,
  output logic [MstIdWidth-1:0]   gnt_id_o,
  output addr_t                   gnt_addr_o,
  output len_t                    gnt_len_o
);

  typedef logic [IdxWidth-1:0] idx_t;

  idx_t rr_q;
  idx_t lock_idx_q;
  logic lock_q;
  idx_t rr_idx;
  idx_t sel_idx;
  logic rr_found;
  logic xfer;

  // --------------------
  // Selection
  // --------------------

  // First requesting port at or after the priority pointer
  always_comb begin
    int unsigned cand;
    rr_found = 1'b0;
    rr_idx   = rr_q;
    for (int unsigned k = 0; k < NumPorts; k++) begin
      cand = (rr_q + k) % NumPorts;
      if (!rr_found && req_valid_i[cand]) begin
        rr_found = 1'b1;
        rr_idx   = idx_t'(cand);
      end
    end
  end

  // A pending grant keeps its port
  assign sel_idx = lock_q ? lock_idx_q : rr_idx;

  // If nothing was found rr_idx points at an idle port
  assign gnt_valid_o = req_valid_i[sel_idx];
  assign xfer        = gnt_valid_o & gnt_ready_i;

  always_comb begin
    req_ready_o          = '0;
    req_ready_o[sel_idx] = gnt_ready_i;
  end

  // Port index goes above the manager ID
  assign gnt_id_o   = {sel_idx, req_id_i[sel_idx]};
  assign gnt_addr_o = req_addr_i[sel_idx];
  assign gnt_len_o  = req_len_i[sel_idx];

  // --------------------
  // Pointer and lock
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (xfer) begin
      lock_q <= 1'b0;
      // Move priority past the port just served
      rr_q   <= (sel_idx == idx_t'(NumPorts - 1)) ? '0 : sel_idx + 1'b1;
    end else if (gnt_valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= sel_idx;
    end
  end

endmodule

/* hw/aw_issue_ctrl.sv */
// --------------------
// Issue control for the arbitrated AW
// The route is pushed once, in the first cycle of valid
// AW valid is never a function of the W channel
// --------------------
module aw_issue_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic arb_valid_i,
  input  logic route_full_i,
  input  logic mst_aw_ready_i,
  output logic arb_ready_o,
  output logic mst_aw_valid_o,
  output logic route_push_o
);

  typedef enum logic {
    AwIdle,
    AwHold
  } aw_state_e;

  aw_state_e state_q;
  aw_state_e state_d;

  always_comb begin
    state_d        = state_q;
    arb_ready_o    = 1'b0;
    mst_aw_valid_o = 1'b0;
    route_push_o   = 1'b0;
    unique case (state_q)
      AwIdle: begin
        // New AW only when the route FIFO has space for it
        if (arb_valid_i && !route_full_i) begin
          mst_aw_valid_o = 1'b1;
          route_push_o   = 1'b1;
          if (mst_aw_ready_i) begin
            arb_ready_o = 1'b1;
          end else begin
            state_d = AwHold;
          end
        end
      end
      AwHold: begin
        // Route already pushed, just wait for the subordinate
        mst_aw_valid_o = 1'b1;
        if (mst_aw_ready_i) begin
          arb_ready_o = 1'b1;
          state_d     = AwIdle;
        end
      end
      default: begin
        state_d = AwIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= AwIdle;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* hw/w_route_fifo.sv */
// --------------------
// FIFO of port indices for write bursts still owed on W
// Holds up to MaxWTrans entries, a push is readable next cycle
// Push while full and pop while empty are ignored
// --------------------
module w_route_fifo #(
  parameter int unsigned  NumPorts  = 4,
  parameter int unsigned  MaxWTrans = 4,
  localparam int unsigned IdxWidth  = $clog2(NumPorts),
  localparam int unsigned PtrWidth  = (MaxWTrans > 1) ? $clog2(MaxWTrans) : 1,
  localparam int unsigned CntWidth  = $clog2(MaxWTrans + 1)
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                push_i,
  input  logic [IdxWidth-1:0] push_idx_i,
  input  logic                pop_i,
  output logic [IdxWidth-1:0] head_idx_o,
  output logic                full_o,
  output logic                empty_o
);

  logic [IdxWidth-1:0] mem_q [MaxWTrans];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] cnt_q;
  logic                push_ok;
  logic                pop_ok;

  assign full_o     = (cnt_q == CntWidth'(MaxWTrans));
  assign empty_o    = (cnt_q == '0);
  assign push_ok    = push_i & ~full_o;
  assign pop_ok     = pop_i & ~empty_o;
  assign head_idx_o = mem_q[rd_ptr_q];

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= push_idx_i;
    end
  end

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(MaxWTrans - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(MaxWTrans - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Count unchanged when both happen
      if (push_ok && !pop_ok) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

/* hw/w_steer.sv */
// --------------------
// W channel steering from the port at the route FIFO head
// Without a route no W beat passes, whatever the ports offer
// --------------------
module w_steer import axi_mux_pkg::*; #(
  parameter int unsigned  NumPorts = 4,
  localparam int unsigned IdxWidth = $clog2(NumPorts)
) (
  input  logic                  route_empty_i,
  input  logic [IdxWidth-1:0]   route_idx_i,
  input  logic [NumPorts-1:0]   slv_w_valid_i,
  input  data_t [NumPorts-1:0]  slv_w_data_i,
  input  strb_t [NumPorts-1:0]  slv_w_strb_i,
  input  logic [NumPorts-1:0]   slv_w_last_i,
  input  logic                  mst_w_ready_i,
  output logic [NumPorts-1:0]   slv_w_ready_o,
  output logic                  mst_w_valid_o,
  output data_t                 mst_w_data_o,
  output strb_t                 mst_w_strb_o,
  output logic                  mst_w_last_o,
  output logic                  route_pop_o
);

  // Payload follows the head index, valid is gated
  assign mst_w_data_o  = slv_w_data_i[route_idx_i];
  assign mst_w_strb_o  = slv_w_strb_i[route_idx_i];
  assign mst_w_last_o  = slv_w_last_i[route_idx_i];
  assign mst_w_valid_o = ~route_empty_i & slv_w_valid_i[route_idx_i];

  // Ready goes back to the owning port only
  always_comb begin
    slv_w_ready_o = '0;
    if (!route_empty_i) begin
      slv_w_ready_o[route_idx_i] = mst_w_ready_i;
    end
  end

  // Burst done, release its route entry
  assign route_pop_o = mst_w_valid_o & mst_w_ready_i & mst_w_last_o;

endmodule

/* hw/resp_router.sv */
// --------------------
// Routes a B or R response to the port in the upper ID bits
// IDs with an index beyond NumPorts are not expected
// --------------------
module resp_router import axi_mux_pkg::*; #(
  parameter int unsigned  NumPorts     = 4,
  parameter int unsigned  PayloadWidth = RespWidth,
  localparam int unsigned IdxWidth     = $clog2(NumPorts),
  localparam int unsigned MstIdWidth   = SlvIdWidth + IdxWidth
) (
  input  logic                                  mst_valid_i,
  input  logic [MstIdWidth-1:0]                 mst_id_i,
  input  logic [PayloadWidth-1:0]               mst_payload_i,
  input  logic [NumPorts-1:0]                   slv_ready_i,
  output logic                                  mst_ready_o,
  output logic [NumPorts-1:0]                   slv_valid_o,
  output slv_id_t [NumPorts-1:0]                slv_id_o,
  output logic [NumPorts-1:0][PayloadWidth-1:0] slv_payload_o
);

  logic [IdxWidth-1:0] dst_idx;

  // Destination port sits above the manager ID
  assign dst_idx = mst_id_i[SlvIdWidth +: IdxWidth];

  always_comb begin
    slv_valid_o          = '0;
    slv_valid_o[dst_idx] = mst_valid_i;
  end

  assign mst_ready_o = slv_ready_i[dst_idx];

  // Every port sees the same stripped ID and payload
  assign slv_id_o      = {NumPorts{mst_id_i[SlvIdWidth-1:0]}};
  assign slv_payload_o = {NumPorts{mst_payload_i}};

endmodule

/* hw/axi_mux.sv */
// --------------------
// AXI4 multiplexer, NumPorts manager ports onto one subordinate
// Subordinate IDs are clog2(NumPorts) bits wider than manager IDs
// Responses return by those bits, NumPorts must be at least 2
// At most MaxWTrans AW bursts may wait for their W data
// --------------------
module axi_mux import axi_mux_pkg::*; #(
  parameter int unsigned  NumPorts      = 4,
  parameter int unsigned  MaxWTrans     = 4,
  localparam int unsigned IdxWidth      = $clog2(NumPorts),
  localparam int unsigned MstIdWidth    = SlvIdWidth + IdxWidth,
  localparam int unsigned RPayloadWidth = RespWidth + DataWidth + 1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Manager ports
  input  logic [NumPorts-1:0]   slv_aw_valid_i,
  input  slv_id_t [NumPorts-1:0] slv_aw_id_i,
  input  addr_t [NumPorts-1:0]  slv_aw_addr_i,
  input  len_t [NumPorts-1:0]   slv_aw_len_i,
  output logic [NumPorts-1:0]   slv_aw_ready_o,
  input  logic [NumPorts-1:0]   slv_w_valid_i,
  input  data_t [NumPorts-1:0]  slv_w_data_i,
  input  strb_t [NumPorts-1:0]  slv_w_strb_i,
  input  logic [NumPorts-1:0]   slv_w_last_i,
  output logic [NumPorts-1:0]   slv_w_ready_o,
  output logic [NumPorts-1:0]   slv_b_valid_o,
  output slv_id_t [NumPorts-1:0] slv_b_id_o,
  output resp_t [NumPorts-1:0]  slv_b_resp_o,
  input  logic [NumPorts-1:0]   slv_b_ready_i,
  input  logic [NumPorts-1:0]   slv_ar_valid_i,
  input  slv_id_t [NumPorts-1:0] slv_ar_id_i,
  input  addr_t [NumPorts-1:0]  slv_ar_addr_i,
  input  len_t [NumPorts-1:0]   slv_ar_len_i,
  output logic [NumPorts-1:0]   slv_ar_ready_o,
  output logic [NumPorts-1:0]   slv_r_valid_o,
  output slv_id_t [NumPorts-1:0] slv_r_id_o,
  output data_t [NumPorts-1:0]  slv_r_data_o,
  output resp_t [NumPorts-1:0]  slv_r_resp_o,
  output logic [NumPorts-1:0]   slv_r_last_o,
  input  logic [NumPorts-1:0]   slv_r_ready_i,
  // Subordinate port
  output logic                  mst_aw_valid_o,
  output logic [MstIdWidth-1:0] mst_aw_id_o,
  output addr_t                 mst_aw_addr_o,
  output len_t                  mst_aw_len_o,
  input  logic                  mst_aw_ready_i,
  output logic                  mst_w_valid_o,
  output data_t                 mst_w_data_o,
  output strb_t                 mst_w_strb_o,
  output logic                  mst_w_last_o,
  input  logic                  mst_w_ready_i,
  input  logic                  mst_b_valid_i,
  input  logic [MstIdWidth-1:0] mst_b_id_i,
  input  resp_t                 mst_b_resp_i,
  output logic                  mst_b_ready_o,
  output logic                  mst_ar_valid_o,
  output logic [MstIdWidth-1:0] mst_ar_id_o,
  output addr_t                 mst_ar_addr_o,
  output len_t                  mst_ar_len_o,
  input  logic                  mst_ar_ready_i,
  input  logic                  mst_r_valid_i,
  input  logic [MstIdWidth-1:0] mst_r_id_i,
  input  data_t                 mst_r_data_i,
  input  resp_t                 mst_r_resp_i,
  input  logic                  mst_r_last_i,
  output logic                  mst_r_ready_o
);

  logic                                   aw_arb_valid;
  logic                                   aw_arb_ready;
  logic                                   route_push;
  logic                                   route_pop;
  logic                                   route_full;
  logic                                   route_empty;
  logic [IdxWidth-1:0]                    route_head;
  logic [NumPorts-1:0][RPayloadWidth-1:0] r_payload;

  // --------------------
  // AW and W
  // --------------------
  rr_arbiter #(.NumPorts(NumPorts)) u_aw_arb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (slv_aw_valid_i),
    .req_id_i    (slv_aw_id_i),
    .req_addr_i  (slv_aw_addr_i),
    .req_len_i   (slv_aw_len_i),
    .gnt_ready_i (aw_arb_ready),
    .req_ready_o (slv_aw_ready_o),
    .gnt_valid_o (aw_arb_valid),
    .gnt_id_o    (mst_aw_id_o),
    .gnt_addr_o  (mst_aw_addr_o),
    .gnt_len_o   (mst_aw_len_o)
  );

  aw_issue_ctrl u_aw_issue_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .arb_valid_i    (aw_arb_valid),
    .route_full_i   (route_full),
    .mst_aw_ready_i (mst_aw_ready_i),
    .arb_ready_o    (aw_arb_ready),
    .mst_aw_valid_o (mst_aw_valid_o),
    .route_push_o   (route_push)
  );

  // Route entry is the port index carried in the AW ID
  w_route_fifo #(.NumPorts(NumPorts), .MaxWTrans(MaxWTrans)) u_w_route_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (route_push),
    .push_idx_i (mst_aw_id_o[SlvIdWidth +: IdxWidth]),
    .pop_i      (route_pop),
    .head_idx_o (route_head),
    .full_o     (route_full),
    .empty_o    (route_empty)
  );

  w_steer #(.NumPorts(NumPorts)) u_w_steer (
    .route_empty_i (route_empty),
    .route_idx_i   (route_head),
    .slv_w_valid_i (slv_w_valid_i),
    .slv_w_data_i  (slv_w_data_i),
    .slv_w_strb_i  (slv_w_strb_i),
    .slv_w_last_i  (slv_w_last_i),
    .mst_w_ready_i (mst_w_ready_i),
    .slv_w_ready_o (slv_w_ready_o),
    .mst_w_valid_o (mst_w_valid_o),
    .mst_w_data_o  (mst_w_data_o),
    .mst_w_strb_o  (mst_w_strb_o),
    .mst_w_last_o  (mst_w_last_o),
    .route_pop_o   (route_pop)
  );

  // --------------------
  // AR
  // --------------------
  rr_arbiter #(.NumPorts(NumPorts)) u_ar_arb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (slv_ar_valid_i),
    .req_id_i    (slv_ar_id_i),
    .req_addr_i  (slv_ar_addr_i),
    .req_len_i   (slv_ar_len_i),
    .gnt_ready_i (mst_ar_ready_i),
    .req_ready_o (slv_ar_ready_o),
    .gnt_valid_o (mst_ar_valid_o),
    .gnt_id_o    (mst_ar_id_o),
    .gnt_addr_o  (mst_ar_addr_o),
    .gnt_len_o   (mst_ar_len_o)
  );

  // --------------------
  // B and R
  // --------------------
  resp_router #(.NumPorts(NumPorts), .PayloadWidth(RespWidth)) u_b_router (
    .mst_valid_i   (mst_b_valid_i),
    .mst_id_i      (mst_b_id_i),
    .mst_payload_i (mst_b_resp_i),
    .slv_ready_i   (slv_b_ready_i),
    .mst_ready_o   (mst_b_ready_o),
    .slv_valid_o   (slv_b_valid_o),
    .slv_id_o      (slv_b_id_o),
    .slv_payload_o (slv_b_resp_o)
  );

  resp_router #(.NumPorts(NumPorts), .PayloadWidth(RPayloadWidth)) u_r_router (
    .mst_valid_i   (mst_r_valid_i),
    .mst_id_i      (mst_r_id_i),
    .mst_payload_i ({mst_r_resp_i, mst_r_data_i, mst_r_last_i}),
    .slv_ready_i   (slv_r_ready_i),
    .mst_ready_o   (mst_r_ready_o),
    .slv_valid_o   (slv_r_valid_o),
    .slv_id_o      (slv_r_id_o),
    .slv_payload_o (r_payload)
  );

  // Split the R payload back into its fields
  for (genvar i = 0; i < NumPorts; i++) begin : gen_r_split
    assign slv_r_resp_o[i] = r_payload[i][DataWidth+1 +: RespWidth];
    assign slv_r_data_o[i] = r_payload[i][1 +: DataWidth];
    assign slv_r_last_o[i] = r_payload[i][0];
  end

endmodule

/* tb/tb_axi_mux_model.svh */
// --------------------
// Reference model and checkers for the AXI mux testbench
// Included inside tb_axi_mux and uses its signals directly
// The first error ends the run
// --------------------
`ifndef TB_AXI_MUX_MODEL_SVH
`define TB_AXI_MUX_MODEL_SVH

typedef struct packed {
  slv_id_t id;
  addr_t   addr;
  len_t    len;
} req_t;

typedef struct packed {
  data_t data;
  strb_t strb;
  logic  last;
} beat_t;

// Requests and beats raised by each port, oldest first
req_t                  aw_exp [NumPorts][$];
req_t                  ar_exp [NumPorts][$];
beat_t                 w_beats [NumPorts][$];
// Owning port of each AW in master order
int                    w_order [$];
// Accepted AW and AR, waiting for B or R
logic [MstIdWidth-1:0] b_todo [$];
logic [MstIdWidth-1:0] r_id_todo [$];
len_t                  r_len_todo [$];
int                    w_bursts_done;
int                    aw_wait [NumPorts];
logic                  aw_open;

task automatic fail_run(input string why);
  $display("%s", why);
  $display("SOME TESTS FAILED");
  $fatal(1);
endtask

task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
  if (got !== exp) begin
    fail_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
  end
endtask

task automatic check_idle();
  check_eq("mst_aw_valid_o", 64'(mst_aw_valid_o), 64'(0));
  check_eq("mst_w_valid_o", 64'(mst_w_valid_o), 64'(0));
  check_eq("mst_ar_valid_o", 64'(mst_ar_valid_o), 64'(0));
  check_eq("slv_b_valid_o", 64'(slv_b_valid_o), 64'(0));
  check_eq("slv_r_valid_o", 64'(slv_r_valid_o), 64'(0));
endtask

task automatic check_aw_master();
  int   idx;
  req_t exp;
  idx = int'(mst_aw_id_o[MstIdWidth-1:SlvIdWidth]);
  // A port transfer happens exactly with the master transfer for that port
  for (int p = 0; p < NumPorts; p++) begin
    check_eq($sformatf("slv_aw_ready_o[%0d]", p), 64'(slv_aw_valid_i[p] && slv_aw_ready_o[p]),
             64'(mst_aw_valid_o && mst_aw_ready_i && p == idx));
  end
  // The route is taken when AW first shows up
  if (mst_aw_valid_o && !aw_open) begin
    w_order.push_back(idx);
    aw_open = 1'b1;
  end
  if (mst_aw_valid_o && mst_aw_ready_i) begin
    if (aw_exp[idx].size() == 0) begin
      fail_run($sformatf("AW at the master for port %0d, which has none pending", idx));
    end else begin
      exp = aw_exp[idx].pop_front();
      check_eq("mst_aw_id_o", 64'(mst_aw_id_o[SlvIdWidth-1:0]), 64'(exp.id));
      check_eq("mst_aw_addr_o", 64'(mst_aw_addr_o), 64'(exp.addr));
      check_eq("mst_aw_len_o", 64'(mst_aw_len_o), 64'(exp.len));
      b_todo.push_back(mst_aw_id_o);
      aw_open = 1'b0;
    end
  end
endtask

// No port waits behind more than NumPorts-1 grants
task automatic check_aw_fairness();
  for (int q = 0; q < NumPorts; q++) begin
    if (slv_aw_valid_i[q] && slv_aw_ready_o[q]) begin
      aw_wait[q] = 0;
      for (int p = 0; p < NumPorts; p++) begin
        if (p != q && slv_aw_valid_i[p]) begin
          aw_wait[p]++;
          if (aw_wait[p] > NumPorts - 1) begin
            fail_run($sformatf("Port %0d was passed over by too many AW grants", p));
          end
        end
      end
    end
  end
endtask

task automatic check_w_master();
  int    idx;
  beat_t exp;
  // Only the port owning the oldest open burst may see its beat taken
  for (int p = 0; p < NumPorts; p++) begin
    check_eq($sformatf("slv_w_ready_o[%0d]", p), 64'(slv_w_valid_i[p] && slv_w_ready_o[p]),
             64'(mst_w_valid_o && mst_w_ready_i && w_order.size() > 0 && w_order[0] == p));
  end
  if (mst_w_valid_o && mst_w_ready_i) begin
    if (w_order.size() == 0) begin
      fail_run("W beat at the master before any AW was issued");
    end else if (w_beats[w_order[0]].size() == 0) begin
      fail_run($sformatf("W beat at the master that port %0d never sent", w_order[0]));
    end else begin
      idx = w_order[0];
      exp = w_beats[idx].pop_front();
      check_eq("mst_w_data_o", 64'(mst_w_data_o), 64'(exp.data));
      check_eq("mst_w_strb_o", 64'(mst_w_strb_o), 64'(exp.strb));
      check_eq("mst_w_last_o", 64'(mst_w_last_o), 64'(exp.last));
      if (mst_w_last_o) begin
        void'(w_order.pop_front());
        w_bursts_done++;
      end
    end
  end
endtask

task automatic check_ar_master();
  int   idx;
  req_t exp;
  idx = int'(mst_ar_id_o[MstIdWidth-1:SlvIdWidth]);
  for (int p = 0; p < NumPorts; p++) begin
    check_eq($sformatf("slv_ar_ready_o[%0d]", p), 64'(slv_ar_valid_i[p] && slv_ar_ready_o[p]),
             64'(mst_ar_valid_o && mst_ar_ready_i && p == idx));
  end
  if (mst_ar_valid_o && mst_ar_ready_i) begin
    if (ar_exp[idx].size() == 0) begin
      fail_run($sformatf("AR at the master for port %0d, which has none pending", idx));
    end else begin
      exp = ar_exp[idx].pop_front();
      check_eq("mst_ar_id_o", 64'(mst_ar_id_o[SlvIdWidth-1:0]), 64'(exp.id));
      check_eq("mst_ar_addr_o", 64'(mst_ar_addr_o), 64'(exp.addr));
      check_eq("mst_ar_len_o", 64'(mst_ar_len_o), 64'(exp.len));
      r_id_todo.push_back(mst_ar_id_o);
      r_len_todo.push_back(mst_ar_len_o);
    end
  end
endtask

// B and R go to the port in the upper ID bits and nowhere else
task automatic check_resp_routes();
  int bd;
  int rd;
  bd = int'(mst_b_id_i[MstIdWidth-1:SlvIdWidth]);
  rd = int'(mst_r_id_i[MstIdWidth-1:SlvIdWidth]);
  for (int p = 0; p < NumPorts; p++) begin
    check_eq($sformatf("slv_b_valid_o[%0d]", p), 64'(slv_b_valid_o[p]),
             64'(mst_b_valid_i && p == bd));
    check_eq($sformatf("slv_r_valid_o[%0d]", p), 64'(slv_r_valid_o[p]),
             64'(mst_r_valid_i && p == rd));
  end
  if (mst_b_valid_i) begin
    check_eq("slv_b_id_o", 64'(slv_b_id_o[bd]), 64'(mst_b_id_i[SlvIdWidth-1:0]));
    check_eq("slv_b_resp_o", 64'(slv_b_resp_o[bd]), 64'(mst_b_resp_i));
    check_eq("mst_b_ready_o", 64'(mst_b_ready_o), 64'(slv_b_ready_i[bd]));
    if (mst_b_ready_o) begin
      b_rcv[bd]++;
    end
  end
  if (mst_r_valid_i) begin
    check_eq("slv_r_id_o", 64'(slv_r_id_o[rd]), 64'(mst_r_id_i[SlvIdWidth-1:0]));
    check_eq("slv_r_data_o", 64'(slv_r_data_o[rd]), 64'(mst_r_data_i));
    check_eq("slv_r_resp_o", 64'(slv_r_resp_o[rd]), 64'(mst_r_resp_i));
    check_eq("slv_r_last_o", 64'(slv_r_last_o[rd]), 64'(mst_r_last_i));
    check_eq("mst_r_ready_o", 64'(mst_r_ready_o), 64'(slv_r_ready_i[rd]));
    if (mst_r_ready_o && mst_r_last_i) begin
      r_rcv[rd]++;
    end
  end
endtask

// Every request and beat must have been seen exactly once
task automatic check_drained();
  for (int p = 0; p < NumPorts; p++) begin
    if (aw_exp[p].size() != 0 || ar_exp[p].size() != 0 || w_beats[p].size() != 0) begin
      fail_run($sformatf("Port %0d has requests or beats that never reached the master", p));
    end
  end
  if (w_order.size() != 0 || b_todo.size() != 0) begin
    fail_run("Write bursts are left without W data or B response");
  end
endtask

`endif

/* tb/tb_axi_mux.sv */
// --------------------
// Testbench for the AXI4 multiplexer with four random managers
// and a random subordinate, checked against an internal model
// Bursts are 1 to 4 beats, each port issues NumTxn of each kind
// --------------------
module tb_axi_mux import axi_mux_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumPorts       = 4;
  localparam int MaxWTrans      = 4;
  localparam int IdxWidth       = $clog2(NumPorts);
  localparam int MstIdWidth     = SlvIdWidth + IdxWidth;
  localparam int NumTxn         = 20;
  localparam int MaxBeats       = 4;
  localparam int WatchdogCycles = NumTxn * NumPorts * 2 * MaxBeats * 50;

  logic clk_i;
  logic rst_ni;
  logic [NumPorts-1:0]   slv_aw_valid_i;
  slv_id_t [NumPorts-1:0] slv_aw_id_i;
  addr_t [NumPorts-1:0]  slv_aw_addr_i;
  len_t [NumPorts-1:0]   slv_aw_len_i;
  logic [NumPorts-1:0]   slv_aw_ready_o;
  logic [NumPorts-1:0]   slv_w_valid_i;
  data_t [NumPorts-1:0]  slv_w_data_i;
  strb_t [NumPorts-1:0]  slv_w_strb_i;
  logic [NumPorts-1:0]   slv_w_last_i;
  logic [NumPorts-1:0]   slv_w_ready_o;
  logic [NumPorts-1:0]   slv_b_valid_o;
  slv_id_t [NumPorts-1:0] slv_b_id_o;
  resp_t [NumPorts-1:0]  slv_b_resp_o;
  logic [NumPorts-1:0]   slv_b_ready_i;
  logic [NumPorts-1:0]   slv_ar_valid_i;
  slv_id_t [NumPorts-1:0] slv_ar_id_i;
  addr_t [NumPorts-1:0]  slv_ar_addr_i;
  len_t [NumPorts-1:0]   slv_ar_len_i;
  logic [NumPorts-1:0]   slv_ar_ready_o;
  logic [NumPorts-1:0]   slv_r_valid_o;
  slv_id_t [NumPorts-1:0] slv_r_id_o;
  data_t [NumPorts-1:0]  slv_r_data_o;
  resp_t [NumPorts-1:0]  slv_r_resp_o;
  logic [NumPorts-1:0]   slv_r_last_o;
  logic [NumPorts-1:0]   slv_r_ready_i;
  logic                  mst_aw_valid_o;
  logic [MstIdWidth-1:0] mst_aw_id_o;
  addr_t                 mst_aw_addr_o;
  len_t                  mst_aw_len_o;
  logic                  mst_aw_ready_i;
  logic                  mst_w_valid_o;
  data_t                 mst_w_data_o;
  strb_t                 mst_w_strb_o;
  logic                  mst_w_last_o;
  logic                  mst_w_ready_i;
  logic                  mst_b_valid_i;
  logic [MstIdWidth-1:0] mst_b_id_i;
  resp_t                 mst_b_resp_i;
  logic                  mst_b_ready_o;
  logic                  mst_ar_valid_o;
  logic [MstIdWidth-1:0] mst_ar_id_o;
  addr_t                 mst_ar_addr_o;
  len_t                  mst_ar_len_o;
  logic                  mst_ar_ready_i;
  logic                  mst_r_valid_i;
  logic [MstIdWidth-1:0] mst_r_id_i;
  data_t                 mst_r_data_i;
  resp_t                 mst_r_resp_i;
  logic                  mst_r_last_i;
  logic                  mst_r_ready_o;

  integer seed;
  logic   run;
  logic   all_done;
  // Manager side bookkeeping
  int   aw_sent [NumPorts];
  int   ar_sent [NumPorts];
  int   b_rcv [NumPorts];
  int   r_rcv [NumPorts];
  int   w_beat [NumPorts];
  int   w_len [NumPorts][$];
  logic aw_busy [NumPorts];
  logic ar_busy [NumPorts];
  logic w_busy [NumPorts];
  // Subordinate side bookkeeping
  int   b_issued;
  logic b_busy;
  logic r_busy;
  int   r_beat;
  int   r_len_cur;

  `include "tb_axi_mux_model.svh"

  axi_mux #(.NumPorts(NumPorts), .MaxWTrans(MaxWTrans)) u_axi_mux (.*);

  always #20 clk_i = ~clk_i;

  // --------------------
  // Managers
  // --------------------
  task automatic drive_managers();
    logic [31:0] rnd;
    req_t        req;
    beat_t       beat;
    for (int p = 0; p < NumPorts; p++) begin
      if (aw_busy[p] && slv_aw_ready_o[p]) begin
        aw_busy[p] = 1'b0;
        slv_aw_valid_i[p] <= 1'b0;
      end
      rnd = $random(seed);
      if (!aw_busy[p] && aw_sent[p] < NumTxn && rnd[0]) begin
        req.id   = rnd[7:4];
        req.addr = $random(seed);
        req.len  = len_t'(rnd[9:8]);
        slv_aw_valid_i[p] <= 1'b1;
        slv_aw_id_i[p]    <= req.id;
        slv_aw_addr_i[p]  <= req.addr;
        slv_aw_len_i[p]   <= req.len;
        aw_exp[p].push_back(req);
        w_len[p].push_back(int'(req.len));
        aw_sent[p]++;
        aw_busy[p] = 1'b1;
      end
      // W data of this port's own bursts, in order
      if (w_busy[p] && slv_w_ready_o[p]) begin
        w_busy[p] = 1'b0;
        slv_w_valid_i[p] <= 1'b0;
        if (w_beat[p] == w_len[p][0]) begin
          void'(w_len[p].pop_front());
          w_beat[p] = 0;
        end else begin
          w_beat[p]++;
        end
      end
      if (!w_busy[p] && w_len[p].size() > 0 && rnd[1]) begin
        beat.data = $random(seed);
        beat.strb = rnd[13:10];
        beat.last = (w_beat[p] == w_len[p][0]);
        slv_w_valid_i[p] <= 1'b1;
        slv_w_data_i[p]  <= beat.data;
        slv_w_strb_i[p]  <= beat.strb;
        slv_w_last_i[p]  <= beat.last;
        w_beats[p].push_back(beat);
        w_busy[p] = 1'b1;
      end
      if (ar_busy[p] && slv_ar_ready_o[p]) begin
        ar_busy[p] = 1'b0;
        slv_ar_valid_i[p] <= 1'b0;
      end
      if (!ar_busy[p] && ar_sent[p] < NumTxn && rnd[2]) begin
        req.id   = rnd[17:14];
        req.addr = $random(seed);
        req.len  = len_t'(rnd[19:18]);
        slv_ar_valid_i[p] <= 1'b1;
        slv_ar_id_i[p]    <= req.id;
        slv_ar_addr_i[p]  <= req.addr;
        slv_ar_len_i[p]   <= req.len;
        ar_exp[p].push_back(req);
        ar_sent[p]++;
        ar_busy[p] = 1'b1;
      end
      slv_b_ready_i[p] <= rnd[20];
      slv_r_ready_i[p] <= rnd[21];
    end
  endtask

  // --------------------
  // Subordinate
  // --------------------
  task automatic drive_subordinate();
    logic [31:0] rnd;
    rnd = $random(seed);
    mst_aw_ready_i <= rnd[0];
    mst_w_ready_i  <= rnd[1];
    mst_ar_ready_i <= rnd[2];
    if (b_busy && mst_b_ready_o) begin
      b_busy = 1'b0;
      mst_b_valid_i <= 1'b0;
    end
    // A B only once its AW is accepted and its last W beat has passed
    if (!b_busy && b_issued < w_bursts_done && b_todo.size() > 0 && rnd[3]) begin
      mst_b_valid_i <= 1'b1;
      mst_b_id_i    <= b_todo.pop_front();
      mst_b_resp_i  <= rnd[5:4];
      b_issued++;
      b_busy = 1'b1;
    end
    if (r_busy && mst_r_ready_o) begin
      if (r_beat == r_len_cur) begin
        r_busy = 1'b0;
        mst_r_valid_i <= 1'b0;
      end else begin
        r_beat++;
        mst_r_data_i <= $random(seed);
        mst_r_resp_i <= rnd[7:6];
        mst_r_last_i <= (r_beat == r_len_cur);
      end
    end
    if (!r_busy && r_id_todo.size() > 0 && rnd[8]) begin
      r_len_cur = int'(r_len_todo.pop_front());
      r_beat    = 0;
      mst_r_valid_i <= 1'b1;
      mst_r_id_i    <= r_id_todo.pop_front();
      mst_r_data_i  <= $random(seed);
      mst_r_resp_i  <= rnd[7:6];
      mst_r_last_i  <= (r_len_cur == 0);
      r_busy = 1'b1;
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_ni && !run) begin
      check_idle();
    end else if (run) begin
      check_aw_master();
      check_aw_fairness();
      check_w_master();
      check_ar_master();
      check_resp_routes();
      drive_managers();
      drive_subordinate();
      all_done = 1'b1;
      for (int p = 0; p < NumPorts; p++) begin
        if (aw_sent[p] != NumTxn || ar_sent[p] != NumTxn ||
            b_rcv[p] != NumTxn || r_rcv[p] != NumTxn) begin
          all_done = 1'b0;
        end
      end
    end
  end

  initial begin
    seed           = 55152;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    run            = 1'b0;
    all_done       = 1'b0;
    slv_aw_valid_i = '0;
    slv_aw_id_i    = '0;
    slv_aw_addr_i  = '0;
    slv_aw_len_i   = '0;
    slv_w_valid_i  = '0;
    slv_w_data_i   = '0;
    slv_w_strb_i   = '0;
    slv_w_last_i   = '0;
    slv_b_ready_i  = '0;
    slv_ar_valid_i = '0;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_ar_len_i   = '0;
    slv_r_ready_i  = '0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_valid_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = '0;
    mst_ar_ready_i = 1'b0;
    mst_r_valid_i  = 1'b0;
    mst_r_id_i     = '0;
    mst_r_data_i   = '0;
    mst_r_resp_i   = '0;
    mst_r_last_i   = 1'b0;
    w_bursts_done  = 0;
    aw_open        = 1'b0;
    b_issued       = 0;
    b_busy         = 1'b0;
    r_busy         = 1'b0;
    r_beat         = 0;
    r_len_cur      = 0;
    for (int p = 0; p < NumPorts; p++) begin
      aw_sent[p] = 0;
      ar_sent[p] = 0;
      b_rcv[p]   = 0;
      r_rcv[p]   = 0;
      w_beat[p]  = 0;
      aw_wait[p] = 0;
      aw_busy[p] = 1'b0;
      ar_busy[p] = 1'b0;
      w_busy[p]  = 1'b0;
    end
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    // A few idle cycles to see the reset state
    repeat (4) @(posedge clk_i);
    run <= 1'b1;
    wait (all_done);
    @(posedge clk_i);
    check_drained();
    $display("ALL TESTS PASSED");
    $finish;
  end

  // Watchdog
  initial begin
    #(WatchdogCycles * 40);
    fail_run("Timeout: the transactions did not complete in time");
  end

endmodule

/* sources.f */
+incdir+tb
hw/axi_mux_pkg.sv
hw/rr_arbiter.sv
hw/aw_issue_ctrl.sv
hw/w_route_fifo.sv
hw/w_steer.sv
hw/resp_router.sv
hw/axi_mux.sv
tb/tb_axi_mux.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the AXI mux testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
  -f sources.f \
  --top-module tb_axi_mux \
  -o Vtb_axi_mux

# The simulator exits non-zero on a failure, keep the log either way
./obj_dir/Vtb_axi_mux 2>&1 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
